//--- frontEnd.f
src/mipsPkg.sv
src/decodedInstr.sv
src/instrDecoder.sv
src/regFile.sv
src/branchResolver.sv
src/fetchStage.sv
src/frontEnd.sv
test/frontEndChecker.sv
test/frontEndTb.sv

//--- src/branchResolver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch and jump resolver
// evaluates the branch condition in ID, picks the redirect target
// and forms the link address for jal and jalr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module branchResolver (
    decodedInstr.reader      dec,
    input  wire logic [31:0] pcId,
    input  wire logic [31:0] rsValue,
    input  wire logic [31:0] rtValue,
    output logic             redirect,
    output logic      [31:0] target,
    output logic      [31:0] linkValue
);

    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        taken;

    // delay slot address
    assign pcPlus4 = pcId + 32'd4;

    // sign extended word offset
    assign branchOffset = {{14{dec.imm16[15]}}, dec.imm16, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // region of the delay slot plus the 26 bit index
    assign jumpTarget = {pcPlus4[31:28], dec.jmpIndex, 2'b00};

    // condition per class, jumps always taken
    always_comb begin
        case (dec.cls)
            mipsPkg::clsBeq:  taken = (rsValue == rtValue);
            mipsPkg::clsBne:  taken = (rsValue != rtValue);
            mipsPkg::clsBlez: taken = ($signed(rsValue) <= 32'sd0);
            mipsPkg::clsBgtz: taken = ($signed(rsValue) > 32'sd0);
            mipsPkg::clsJ,
            mipsPkg::clsJal,
            mipsPkg::clsJr,
            mipsPkg::clsJalr: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect = taken;

    // target source
    always_comb begin
        case (dec.cls)
            mipsPkg::clsJ,
            mipsPkg::clsJal:  target = jumpTarget;
            mipsPkg::clsJr,
            mipsPkg::clsJalr: target = rsValue;
            // branches, also a harmless value when nothing redirects
            default:          target = branchTarget;
        endcase
    end

    // return past the delay slot
    always_comb begin
        if (dec.cls == mipsPkg::clsJal || dec.cls == mipsPkg::clsJalr) begin
            linkValue = pcId + 32'd8;
        end else begin
            linkValue = 32'd0;
        end
    end

endmodule

`default_nettype wire

//--- src/decodedInstr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decoded instruction bundle
// fields produced in ID by the decoder for the resolver and the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

interface decodedInstr;

    // instruction class
    mipsPkg::instrClass cls;
    // source register numbers, also the register file read addresses
    logic [4:0]  rs;
    logic [4:0]  rt;
    // register written later, zero when nothing is written
    logic [4:0]  destReg;
    // raw immediate and jump index fields
    logic [15:0] imm16;
    logic [25:0] jmpIndex;

    // decoder side
    modport driver (
        output cls, rs, rt, destReg, imm16, jmpIndex
    );

    // consumers of the decoded fields
    modport reader (
        input cls, rs, rt, destReg, imm16, jmpIndex
    );

endinterface

`default_nettype wire

//--- src/fetchStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage
// PC register with next PC select, instruction ROM and the IF/ID
// pipeline register with stall and flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module fetchStage (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        stall,
    input  wire logic        flush,
    input  wire logic        redirect,
    input  wire logic [31:0] target,
    output logic      [31:0] pcFetch,
    output logic      [31:0] instrId,
    output logic      [31:0] pcId
);

    // program image, word addressed
    logic [31:0] rom [0:mipsPkg::romDepth-1];

    logic [31:0]                     pcOffset;
    logic [mipsPkg::romAddrWidth-1:0] romIndex;
    logic [31:0]                     instrFetch;
    logic [31:0]                     pcNext;

    initial begin
        $readmemh("test/program.hex", rom);
    end

    // byte offset from the text base, then word index
    assign pcOffset   = pcFetch - mipsPkg::textStart;
    assign romIndex   = pcOffset[mipsPkg::romAddrWidth+1:2];
    assign instrFetch = rom[romIndex];

    // resolver target wins over sequential fetch
    assign pcNext = redirect ? target : pcFetch + 32'd4;

    // PC register
    always_ff @(posedge clk) begin
        if (reset) begin
            pcFetch <= mipsPkg::textStart;
        end else if (!stall) begin
            pcFetch <= pcNext;
        end
    end

    // IF/ID register
    // flush beats stall, cleared word decodes as nop
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            instrId <= 32'd0;
            pcId    <= 32'd0;
        end else if (!stall) begin
            instrId <= instrFetch;
            pcId    <= pcFetch;
        end
    end

endmodule

`default_nettype wire

//--- src/frontEnd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS fetch and decode front end
// fetch, decode, register read and branch resolution in ID
// with a single branch delay slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module frontEnd (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        stall,
    input  wire logic        flush,
    input  wire logic        regWrite,
    input  wire logic [4:0]  writeAddr,
    input  wire logic [31:0] writeData,
    output logic      [31:0] pcFetch,
    output logic      [31:0] pcId,
    output logic      [31:0] instrId,
    output logic      [3:0]  instrCls,
    output logic      [4:0]  destReg,
    output logic      [31:0] rsValue,
    output logic      [31:0] rtValue,
    output logic             redirect,
    output logic      [31:0] linkValue
);

    logic [31:0] target;

    // decoded fields of the ID instruction
    decodedInstr dec ();

    fetchStage fetch (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .redirect (redirect),
        .target   (target),
        .pcFetch  (pcFetch),
        .instrId  (instrId),
        .pcId     (pcId)
    );

    instrDecoder decoder (
        .instr (instrId),
        .dec   (dec.driver)
    );

    // read addresses straight from the decoded fields
    regFile regs (
        .clk       (clk),
        .reset     (reset),
        .rsAddr    (dec.rs),
        .rtAddr    (dec.rt),
        .regWrite  (regWrite),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .rsValue   (rsValue),
        .rtValue   (rtValue)
    );

    branchResolver resolver (
        .dec       (dec.reader),
        .pcId      (pcId),
        .rsValue   (rsValue),
        .rtValue   (rtValue),
        .redirect  (redirect),
        .target    (target),
        .linkValue (linkValue)
    );

    // class exported as raw bits
    assign instrCls = 4'(dec.cls);
    assign destReg  = dec.destReg;

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder
// classifies the IF/ID word and slices its register, immediate and
// jump fields, then picks the destination register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
    input  wire logic [31:0] instr,
    decodedInstr.driver      dec
);

    mipsPkg::opcode op;
    mipsPkg::funct  fn;
    logic [4:0]     rd;

    // primary and function fields viewed as enums
    assign op = mipsPkg::opcode'(instr[31:26]);
    assign fn = mipsPkg::funct'(instr[5:0]);
    assign rd = instr[15:11];

    // plain field slices
    assign dec.rs       = instr[25:21];
    assign dec.rt       = instr[20:16];
    assign dec.imm16    = instr[15:0];
    assign dec.jmpIndex = instr[25:0];

    // class lookup
    always_comb begin
        dec.cls = mipsPkg::clsOther;
        if (instr == 32'd0) begin
            // all zero word is the canonical nop
            dec.cls = mipsPkg::clsNop;
        end else begin
            case (op)
                mipsPkg::opSpecial: begin
                    case (fn)
                        mipsPkg::fnJr:   dec.cls = mipsPkg::clsJr;
                        mipsPkg::fnJalr: dec.cls = mipsPkg::clsJalr;
                        mipsPkg::fnAddu,
                        mipsPkg::fnSubu,
                        mipsPkg::fnAnd,
                        mipsPkg::fnOr,
                        mipsPkg::fnSlt:  dec.cls = mipsPkg::clsAlu;
                        default:         dec.cls = mipsPkg::clsOther;
                    endcase
                end
                mipsPkg::opJ:     dec.cls = mipsPkg::clsJ;
                mipsPkg::opJal:   dec.cls = mipsPkg::clsJal;
                mipsPkg::opBeq:   dec.cls = mipsPkg::clsBeq;
                mipsPkg::opBne:   dec.cls = mipsPkg::clsBne;
                mipsPkg::opBlez:  dec.cls = mipsPkg::clsBlez;
                mipsPkg::opBgtz:  dec.cls = mipsPkg::clsBgtz;
                mipsPkg::opLw:    dec.cls = mipsPkg::clsLoad;
                mipsPkg::opSw:    dec.cls = mipsPkg::clsStore;
                // immediate ALU ops
                mipsPkg::opAddiu,
                mipsPkg::opOri,
                mipsPkg::opLui:   dec.cls = mipsPkg::clsAlu;
                default:          dec.cls = mipsPkg::clsOther;
            endcase
        end
    end

    // destination register
    always_comb begin
        case (dec.cls)
            // R-type ALU writes rd, immediate ALU writes rt
            mipsPkg::clsAlu:  dec.destReg = (op == mipsPkg::opSpecial) ? rd : dec.rt;
            mipsPkg::clsJalr: dec.destReg = rd;
            mipsPkg::clsLoad: dec.destReg = dec.rt;
            mipsPkg::clsJal:  dec.destReg = mipsPkg::linkReg;
            // stores, branches, j, jr, nop and unknowns write nothing
            default:          dec.destReg = 5'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/mipsPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS front end shared definitions
// instruction classes, opcode and function encodings, reset PC
// and instruction ROM sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mipsPkg;

    // decoded class of the instruction sitting in ID
    typedef enum logic [3:0] {
        clsNop   = 4'd0,
        clsAlu   = 4'd1,
        clsLoad  = 4'd2,
        clsStore = 4'd3,
        clsBeq   = 4'd4,
        clsBne   = 4'd5,
        clsBlez  = 4'd6,
        clsBgtz  = 4'd7,
        clsJ     = 4'd8,
        clsJal   = 4'd9,
        clsJr    = 4'd10,
        clsJalr  = 4'd11,
        clsOther = 4'd12
    } instrClass;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBlez    = 6'h06,
        opBgtz    = 6'h07,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode;

    // SPECIAL function field, instr[5:0]
    typedef enum logic [5:0] {
        fnJr   = 6'h08,
        fnJalr = 6'h09,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } funct;

    // first instruction address after reset
    localparam logic [31:0] textStart = 32'h0000_3000;

    // instruction ROM, one 32 bit word per entry
    localparam int romDepth     = 256;
    localparam int romAddrWidth = 8;

    // return address register written by jal
    localparam logic [4:0] linkReg = 5'd31;

endpackage

`default_nettype wire

//--- src/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file
// 32 x 32, two read ports with write bypass, one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  rsAddr,
    input  wire logic [4:0]  rtAddr,
    input  wire logic        regWrite,
    input  wire logic [4:0]  writeAddr,
    input  wire logic [31:0] writeData,
    output logic      [31:0] rsValue,
    output logic      [31:0] rtValue
);

    // register zero has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (regWrite && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // one read port, zero reg first, then same cycle write
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = 32'd0;
        end else if (regWrite && writeAddr == addr) begin
            value = writeData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rsValue = readPort(rsAddr);
        rtValue = readPort(rtAddr);
    end

endmodule

`default_nettype wire

//--- test/frontEndChecker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front end result checker
// samples DUT outputs one falling edge after each row and compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module frontEndChecker (
    input  wire logic        clk,
    input  wire logic        rowStrobe,
    input  wire logic [31:0] expPcFetch,
    input  wire logic [31:0] expPcId,
    input  wire logic [31:0] expInstrId,
    input  wire logic [3:0]  expCls,
    input  wire logic [4:0]  expDest,
    input  wire logic [31:0] expRs,
    input  wire logic [31:0] expRt,
    input  wire logic        expRedirect,
    input  wire logic [31:0] expLink,
    input  wire logic [31:0] pcFetch,
    input  wire logic [31:0] pcId,
    input  wire logic [31:0] instrId,
    input  wire logic [3:0]  instrCls,
    input  wire logic [4:0]  destReg,
    input  wire logic [31:0] rsValue,
    input  wire logic [31:0] rtValue,
    input  wire logic        redirect,
    input  wire logic [31:0] linkValue,
    output int               doneCount,
    output int               passCount,
    output int               failCount
);

    // mismatches in the current row
    int errors;

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    initial begin
        doneCount = 0;
        passCount = 0;
        failCount = 0;
        errors    = 0;
    end

    // one compare per strobe toggle, after the edge that row drove
    always begin
        @(rowStrobe);
        @(negedge clk);
        errors = 0;
        compareField("pcFetch", expPcFetch, pcFetch);
        compareField("pcId", expPcId, pcId);
        compareField("instrId", expInstrId, instrId);
        compareField("instrCls", 32'(expCls), 32'(instrCls));
        compareField("destReg", 32'(expDest), 32'(destReg));
        compareField("rsValue", expRs, rsValue);
        compareField("rtValue", expRt, rtValue);
        compareField("redirect", 32'(expRedirect), 32'(redirect));
        compareField("linkValue", expLink, linkValue);
        if (errors == 0) begin
            passCount++;
            $display("test %0d passed", doneCount);
        end else begin
            failCount++;
            $display("test %0d failed with %0d mismatches", doneCount, errors);
        end
        // releases the testbench for the next row
        doneCount++;
    end

endmodule

`default_nettype wire

//--- test/frontEndTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front end testbench
// clock, reset and a cycle table of inputs and expected outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module frontEndTb;

    localparam int maxRows     = 64;
    localparam int rowTimeout  = 10;
    localparam int resetCycles = 8;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    logic        regWrite;
    logic [4:0]  writeAddr;
    logic [31:0] writeData;
    wire  [31:0] pcFetch;
    wire  [31:0] pcId;
    wire  [31:0] instrId;
    wire  [3:0]  instrCls;
    wire  [4:0]  destReg;
    wire  [31:0] rsValue;
    wire  [31:0] rtValue;
    wire         redirect;
    wire  [31:0] linkValue;

    // row under check, handed to the checker
    logic        rowStrobe;
    logic [31:0] expPcFetch;
    logic [31:0] expPcId;
    logic [31:0] expInstrId;
    logic [3:0]  expCls;
    logic [4:0]  expDest;
    logic [31:0] expRs;
    logic [31:0] expRt;
    logic        expRedirect;
    logic [31:0] expLink;
    int          doneCount;
    int          passCount;
    int          failCount;
    integer      seed;

    // stimulus table, one entry per clock cycle
    logic        tStall [maxRows];
    logic        tFlush [maxRows];
    logic        tWrite [maxRows];
    logic [4:0]  tAddr [maxRows];
    logic [31:0] tData [maxRows];
    logic [31:0] tPc [maxRows];
    logic [31:0] tPcId [maxRows];
    logic [31:0] tInstr [maxRows];
    logic [3:0]  tCls [maxRows];
    logic [4:0]  tDest [maxRows];
    logic [31:0] tRs [maxRows];
    logic [31:0] tRt [maxRows];
    logic        tRed [maxRows];
    logic [31:0] tLink [maxRows];
    int          numRows;

    frontEnd DUT (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush),
        .regWrite(regWrite), .writeAddr(writeAddr), .writeData(writeData),
        .pcFetch(pcFetch), .pcId(pcId), .instrId(instrId), .instrCls(instrCls),
        .destReg(destReg), .rsValue(rsValue), .rtValue(rtValue),
        .redirect(redirect), .linkValue(linkValue)
    );

    frontEndChecker resultChecker (
        .clk(clk), .rowStrobe(rowStrobe),
        .expPcFetch(expPcFetch), .expPcId(expPcId), .expInstrId(expInstrId),
        .expCls(expCls), .expDest(expDest), .expRs(expRs), .expRt(expRt),
        .expRedirect(expRedirect), .expLink(expLink),
        .pcFetch(pcFetch), .pcId(pcId), .instrId(instrId), .instrCls(instrCls),
        .destReg(destReg), .rsValue(rsValue), .rtValue(rtValue),
        .redirect(redirect), .linkValue(linkValue),
        .doneCount(doneCount), .passCount(passCount), .failCount(failCount)
    );

    always #50 clk = ~clk;

    task automatic addRow(input logic st, input logic fl, input logic wr, input logic [4:0] wa,
                          input logic [31:0] wd, input logic [31:0] pc, input logic [31:0] pcI,
                          input logic [31:0] ins, input mipsPkg::instrClass cls,
                          input logic [4:0] dst, input logic red, input logic [31:0] lnk);
        tStall[numRows] = st;
        tFlush[numRows] = fl;
        tWrite[numRows] = wr;
        tAddr[numRows]  = wa;
        tData[numRows]  = wd;
        tPc[numRows]    = pc;
        tPcId[numRows]  = pcI;
        tInstr[numRows] = ins;
        tCls[numRows]   = 4'(cls);
        tDest[numRows]  = dst;
        tRs[numRows]    = 32'd0;
        tRt[numRows]    = 32'd0;
        tRed[numRows]   = red;
        tLink[numRows]  = lnk;
        numRows++;
    endtask

    // register read values for the row added last
    task automatic expectOperands(input logic [31:0] rsv, input logic [31:0] rtv);
        tRs[numRows-1] = rsv;
        tRt[numRows-1] = rtv;
    endtask

    // st fl wr wa wd | pcFetch pcId instrId cls destReg redirect linkValue
    // register reads are zero unless set right after the row
    task automatic buildTable();
        numRows = 0;
        // stalled right after reset, stage holds a nop
        addRow(1, 0, 0,  0, 32'h0, 32'h3000, 32'h0, 32'h0, mipsPkg::clsNop, 0, 0, 32'h0);
        // sequential fetch and plain decode, filler writes to 20 and 21
        addRow(0, 0, 0,  0, 32'h0, 32'h3004, 32'h3000, 32'h00221821, mipsPkg::clsAlu, 3, 0, 0);
        addRow(0, 0, 1, 20, 32'h0, 32'h3008, 32'h3004, 32'h8cc50004, mipsPkg::clsLoad, 5, 0, 0);
        addRow(0, 0, 1, 21, 32'h0, 32'h300c, 32'h3008, 32'had070008, mipsPkg::clsStore, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3010, 32'h300c, 32'hfc000000, mipsPkg::clsOther, 0, 0, 0);
        // beq taken, delay slot then target
        addRow(0, 0, 0,  0, 32'h0, 32'h3014, 32'h3010, 32'h114b0002, mipsPkg::clsBeq, 0, 1, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h301c, 32'h3014, 32'h340c0001, mipsPkg::clsAlu, 12, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3020, 32'h301c, 32'h154b0002, mipsPkg::clsBne, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3024, 32'h3020, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3028, 32'h3024, 32'h19400002, mipsPkg::clsBlez, 0, 1, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3030, 32'h3028, 32'h340c0001, mipsPkg::clsAlu, 12, 0, 0);
        // bgtz on $13, taken only through the same cycle write
        addRow(0, 0, 0,  0, 32'h0, 32'h3034, 32'h3030, 32'h1da00002, mipsPkg::clsBgtz, 0, 0, 0);
        addRow(0, 0, 1, 13, 32'h7, 32'h303c, 32'h3034, 32'h340c0001, mipsPkg::clsAlu, 12, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3040, 32'h303c, 32'h1d400002, mipsPkg::clsBgtz, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3044, 32'h3040, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 1, 11, 32'h9, 32'h3048, 32'h3044, 32'h19a00002, mipsPkg::clsBlez, 0, 0, 0);
        expectOperands(32'h7, 32'h0);
        addRow(0, 0, 0,  0, 32'h0, 32'h304c, 32'h3048, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3050, 32'h304c, 32'h114b0002, mipsPkg::clsBeq, 0, 0, 0);
        expectOperands(32'h0, 32'h9);
        addRow(0, 0, 1, 15, 32'h3084, 32'h3054, 32'h3050, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 1, 16, 32'h3090, 32'h3058, 32'h3054, 32'h154b0002, mipsPkg::clsBne, 0, 1, 0);
        expectOperands(32'h0, 32'h9);
        addRow(0, 0, 0,  0, 32'h0, 32'h3060, 32'h3058, 32'h340c0001, mipsPkg::clsAlu, 12, 0, 0);
        // j, jal, jr, jalr
        addRow(0, 0, 0,  0, 32'h0, 32'h3064, 32'h3060, 32'h08000c1b, mipsPkg::clsJ, 0, 1, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h306c, 32'h3064, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3070, 32'h306c, 32'h0c000c1e, mipsPkg::clsJal, 31, 1, 32'h3074);
        addRow(0, 0, 0,  0, 32'h0, 32'h3078, 32'h3070, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h307c, 32'h3078, 32'h01e00008, mipsPkg::clsJr, 0, 1, 0);
        expectOperands(32'h3084, 32'h0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3084, 32'h307c, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3088, 32'h3084, 32'h0200f809, mipsPkg::clsJalr, 31, 1, 32'h308c);
        expectOperands(32'h3090, 32'h0);
        addRow(0, 0, 0,  0, 32'h0, 32'h3090, 32'h3088, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        // beq on $0 while $0 is written, then held across a stall
        addRow(0, 0, 1,  0, 32'h5, 32'h3094, 32'h3090, 32'h100a0002, mipsPkg::clsBeq, 0, 1, 0);
        addRow(1, 0, 0,  0, 32'h0, 32'h3094, 32'h3090, 32'h100a0002, mipsPkg::clsBeq, 0, 1, 0);
        addRow(1, 0, 0,  0, 32'h0, 32'h3094, 32'h3090, 32'h100a0002, mipsPkg::clsBeq, 0, 1, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h309c, 32'h3094, 32'h340c0001, mipsPkg::clsAlu, 12, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h30a0, 32'h309c, 32'h340c0001, mipsPkg::clsAlu, 12, 0, 0);
        // flush over stall on a live word, then flush alone
        addRow(1, 1, 0,  0, 32'h0, 32'h30a0, 32'h0, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 1, 0,  0, 32'h0, 32'h30a4, 32'h0, 32'h0, mipsPkg::clsNop, 0, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h30a8, 32'h30a4, 32'h00221821, mipsPkg::clsAlu, 3, 0, 0);
        addRow(0, 0, 0,  0, 32'h0, 32'h30ac, 32'h30a8, 32'h00221821, mipsPkg::clsAlu, 3, 0, 0);
    endtask

    // drive one row, random data only for filler registers
    task automatic applyRow(input int r);
        stall       = tStall[r];
        flush       = tFlush[r];
        regWrite    = tWrite[r];
        writeAddr   = tAddr[r];
        writeData   = (tAddr[r] >= 5'd20) ? $random(seed) : tData[r];
        expPcFetch  = tPc[r];
        expPcId     = tPcId[r];
        expInstrId  = tInstr[r];
        expCls      = tCls[r];
        expDest     = tDest[r];
        expRs       = tRs[r];
        expRt       = tRt[r];
        expRedirect = tRed[r];
        expLink     = tLink[r];
        rowStrobe   = ~rowStrobe;
    endtask

    initial begin
        int waited;
        int ticks;
        bit timedOut;
        seed      = 32'h7f88_25c7;
        clk       = 1'b0;
        reset     = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        regWrite  = 1'b0;
        writeAddr = 5'd0;
        writeData = 32'd0;
        rowStrobe = 1'b0;
        timedOut  = 1'b0;
        buildTable();
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        waited = 0;
        while (reset && waited < rowTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (reset) begin
            $display("reset was never released");
            timedOut = 1'b1;
        end
        for (int r = 0; r < numRows && !timedOut; r++) begin
            applyRow(r);
            ticks = 0;
            while (doneCount != r + 1 && ticks < rowTimeout) begin
                @(doneCount or posedge clk);
                ticks++;
            end
            if (doneCount != r + 1) begin
                $display("checker gave no result for test %0d in time", r);
                timedOut = 1'b1;
            end
        end
        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (timedOut || failCount != 0 || passCount != numRows) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/program.hex
// one 32 bit instruction word per line, hex, first line at 0x3000
// word n sits at address 0x3000 + 4n
00221821 // addu $3,$1,$2
8cc50004 // lw $5,4($6)
ad070008 // sw $7,8($8)
fc000000 // unknown opcode
114b0002 // beq $10,$11 taken
340c0001 // delay slot
fc000000 // skipped
154b0002 // bne $10,$11 not taken
00000000
19400002 // blez $10 taken
340c0001 // delay slot
fc000000 // skipped
1da00002 // bgtz $13 taken through bypass
340c0001 // delay slot
fc000000 // skipped
1d400002 // bgtz $10 not taken
00000000
19a00002 // blez $13 not taken
00000000
114b0002 // beq $10,$11 not taken
00000000
154b0002 // bne $10,$11 taken
340c0001 // delay slot
fc000000 // skipped
08000c1b // j 0x306c
00000000
fc000000 // skipped
0c000c1e // jal 0x3078
00000000
fc000000 // skipped
01e00008 // jr $15
00000000
fc000000 // skipped
0200f809 // jalr $31,$16
00000000
fc000000 // skipped
100a0002 // beq $0,$10 taken
340c0001 // delay slot
fc000000 // skipped
340c0001
340c0001
00221821
00221821
